/* files.f */
rtl/z80IsaPkg.sv
rtl/z80FrontPkg.sv
rtl/byteQueue.sv
rtl/instrDecoder.sv
rtl/instrAssembler.sv
rtl/z80Front.sv
tests/clockGen.sv
tests/tbZ80Front.sv

/* rtl/byteQueue.sv */
`timescale 1ns/1ps

module byteQueue #(
    parameter int Depth = 8
) (
    input  logic       clk,
    input  logic       rstN,
    input  logic       wrEn,
    input  logic [7:0] wrData,
    input  logic       rdEn,
    output logic [7:0] rdData,
    output logic       full,
    output logic       empty
);

    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW = $clog2(Depth + 1);

    logic [7:0]      mem [Depth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;
    logic            doWrite;
    logic            doRead;

    // Wrap at Depth, which need not be a power of two
    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        if (ptr == PtrW'(Depth - 1)) begin
            nextPtr = '0;
        end else begin
            nextPtr = ptr + 1'b1;
        end
    endfunction

    assign full    = (count == CntW'(Depth));
    assign empty   = (count == '0);
    assign doWrite = wrEn && !full;   // Dropped when full
    assign doRead  = rdEn && !empty;
    assign rdData  = mem[rdPtr];      // Head byte

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr] <= wrData;
        end
    end

    // ****************************************
    // Pointers and occupancy
    // ****************************************
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doRead) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({doWrite, doRead})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle, or write and pop together
            endcase
        end
    end

endmodule

/* rtl/instrAssembler.sv */
`timescale 1ns/1ps

module instrAssembler (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [7:0]            queueData,
    input  logic                  queueEmpty,
    output logic                  queuePop,
    output logic                  insnValid,
    output z80IsaPkg::insnGroup_t insnGroup,
    output logic [15:0]           insnOpcode,
    output logic [1:0]            insnOpLen,
    output logic [15:0]           insnOperand
);

    z80FrontPkg::asmState_t state;
    z80IsaPkg::insnGroup_t  decGroup;
    logic [15:0]            decInstr;
    logic [1:0]             decLen;
    logic [1:0]             decCount;
    logic [1:0]             opndNeed;
    logic [1:0]             opndGot;
    logic                   lastOperand;

    instrDecoder decoder (
        .instr    (decInstr),
        .instrLen (decLen),
        .group    (decGroup)
    );

    // ****************************************
    // Decoder query
    // ****************************************
    // Head byte goes in with whatever opcode bytes are already held
    always_comb begin
        case (state)
            z80FrontPkg::Opcode1: begin
                decInstr = {8'h00, queueData};
                decLen   = queueEmpty ? 2'd0 : 2'd1;
            end
            z80FrontPkg::Opcode2: begin
                decInstr = {queueData, insnOpcode[7:0]};  // Prefix held low
                decLen   = queueEmpty ? 2'd1 : 2'd2;
            end
            default: begin
                decInstr = insnOpcode;
                decLen   = insnOpLen;
            end
        endcase
    end

    assign queuePop    = !queueEmpty;  // Always hungry
    assign decCount    = z80IsaPkg::operandCount(decGroup);
    assign lastOperand = (opndGot + 2'd1 == opndNeed);

    // ****************************************
    // Sequencing
    // ****************************************
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state     <= z80FrontPkg::Opcode1;
            insnValid <= 1'b0;
            opndNeed  <= 2'd0;
            opndGot   <= 2'd0;
        end else begin
            insnValid <= 1'b0;
            if (queuePop) begin
                case (state)
                    z80FrontPkg::Opcode1, z80FrontPkg::Opcode2: begin
                        if (decGroup == z80IsaPkg::NeedMoreBytes) begin
                            state <= z80FrontPkg::Opcode2;
                        end else if (decCount == 2'd0) begin
                            insnValid <= 1'b1;  // Opcode alone, done now
                            state     <= z80FrontPkg::Opcode1;
                        end else begin
                            opndNeed <= decCount;
                            opndGot  <= 2'd0;
                            state    <= z80FrontPkg::Operands;
                        end
                    end
                    default: begin
                        opndGot <= opndGot + 2'd1;
                        if (lastOperand) begin
                            insnValid <= 1'b1;
                            state     <= z80FrontPkg::Opcode1;
                        end
                    end
                endcase
            end
        end
    end

    // Instruction fields, held until the next instruction starts
    always_ff @(posedge clk) begin
        if (queuePop) begin
            case (state)
                z80FrontPkg::Opcode1: begin
                    insnOpcode  <= {8'h00, queueData};
                    insnOpLen   <= 2'd1;
                    insnGroup   <= decGroup;
                    insnOperand <= 16'h0000;
                end
                z80FrontPkg::Opcode2: begin
                    insnOpcode[15:8] <= queueData;
                    insnOpLen        <= 2'd2;
                    insnGroup        <= decGroup;
                    insnOperand      <= 16'h0000;
                end
                default: begin
                    if (opndGot == 2'd0) begin
                        insnOperand[7:0] <= queueData;  // First byte low
                    end else begin
                        insnOperand[15:8] <= queueData;
                    end
                end
            endcase
        end
    end

    // ****************************************
    // Checks
    // ****************************************
    assert property (@(posedge clk) disable iff (!rstN)
        queuePop |-> !queueEmpty)
        else $error("Pop from an empty byte queue");

    assert property (@(posedge clk) disable iff (!rstN)
        (insnValid || state == z80FrontPkg::Operands) |-> insnOpLen inside {2'd1, 2'd2})
        else $error("Opcode length out of range");

endmodule

/* rtl/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
    input  logic [15:0]           instr,
    input  logic [1:0]            instrLen,
    output z80IsaPkg::insnGroup_t group
);

    always_comb begin
        if (instrLen == 2'd0) begin
            group = z80IsaPkg::NeedMoreBytes;
        end else if (instrLen == 2'd1) begin
            // ****************************************
            // Unprefixed opcodes
            // ****************************************
            case (instr[7:0])
                8'h01, 8'h11, 8'h21, 8'h31:
                    group = z80IsaPkg::LdDdImmed;
                8'h02, 8'h12:
                    group = z80IsaPkg::LdBcdeA;
                8'h0a, 8'h1a:
                    group = z80IsaPkg::LdABcde;
                8'h06, 8'h0e, 8'h16, 8'h1e, 8'h26, 8'h2e, 8'h3e:
                    group = z80IsaPkg::LdRegImmed;
                8'h22:
                    group = z80IsaPkg::LdExtaddrHl;
                8'h36:
                    group = z80IsaPkg::LdHlImmed;
                8'h7f, 8'h78, 8'h79, 8'h7a, 8'h7b, 8'h7c, 8'h7d,
                8'h47, 8'h40, 8'h41, 8'h42, 8'h43, 8'h44, 8'h45,
                8'h4f, 8'h48, 8'h49, 8'h4a, 8'h4b, 8'h4c, 8'h4d,
                8'h57, 8'h50, 8'h51, 8'h52, 8'h53, 8'h54, 8'h55,
                8'h5f, 8'h58, 8'h59, 8'h5a, 8'h5b, 8'h5c, 8'h5d,
                8'h67, 8'h60, 8'h61, 8'h62, 8'h63, 8'h64, 8'h65,
                8'h6f, 8'h68, 8'h69, 8'h6a, 8'h6b, 8'h6c, 8'h6d:
                    group = z80IsaPkg::LdRegReg;
                8'h32:
                    group = z80IsaPkg::LdExtaddrA;
                8'h3a:
                    group = z80IsaPkg::LdAExtaddr;
                8'h70, 8'h71, 8'h72, 8'h73, 8'h74, 8'h75, 8'h77:
                    group = z80IsaPkg::LdHlReg;
                z80IsaPkg::PrefixCb, z80IsaPkg::PrefixDd,
                z80IsaPkg::PrefixEd, z80IsaPkg::PrefixFd:
                    group = z80IsaPkg::NeedMoreBytes;
                default:
                    group = z80IsaPkg::IllegalInstr;  // HALT falls here too
            endcase
        end else begin
            // ****************************************
            // Prefixed pairs, prefix in the low byte
            // ****************************************
            case (instr[7:0])
                z80IsaPkg::PrefixEd: begin
                    case (instr[15:8])
                        8'h4b, 8'h5b, 8'h6b, 8'h7b:
                            group = z80IsaPkg::LdDdExtaddr;
                        8'h43, 8'h53, 8'h63, 8'h73:
                            group = z80IsaPkg::LdExtaddrDd;
                        8'h47:
                            group = z80IsaPkg::LdIA;
                        8'h57:
                            group = z80IsaPkg::LdAI;
                        default:
                            group = z80IsaPkg::IllegalInstr;
                    endcase
                end
                z80IsaPkg::PrefixDd, z80IsaPkg::PrefixFd: begin  // IX and IY alike
                    case (instr[15:8])
                        8'h46, 8'h4e, 8'h56, 8'h5e, 8'h66, 8'h6e, 8'h7e:
                            group = z80IsaPkg::LdRegIxiy;
                        8'h70, 8'h71, 8'h72, 8'h73, 8'h74, 8'h75, 8'h77:
                            group = z80IsaPkg::LdIxiyReg;
                        8'h36:
                            group = z80IsaPkg::LdIxiyImmed;
                        8'h22:
                            group = z80IsaPkg::LdExtaddrIxiy;
                        default:
                            group = z80IsaPkg::IllegalInstr;
                    endcase
                end
                default:
                    group = z80IsaPkg::IllegalInstr;  // CB forms not decoded
            endcase
        end
    end

    // A full two-byte opcode always resolves
    always_comb begin
        if (instrLen >= 2'd2) begin
            assert (group != z80IsaPkg::NeedMoreBytes)
                else $error("Decoder left a two-byte opcode unresolved");
        end
    end

endmodule

/* rtl/z80Front.sv */
`timescale 1ns/1ps

module z80Front #(
    parameter int QueueDepth = z80FrontPkg::defaultQueueDepth
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  byteValid,
    input  logic [7:0]            byteData,
    output logic                  byteFull,
    output logic                  insnValid,
    output z80IsaPkg::insnGroup_t insnGroup,
    output logic [15:0]           insnOpcode,
    output logic [1:0]            insnOpLen,
    output logic [15:0]           insnOperand
);

    logic [7:0] queueData;
    logic       queueEmpty;
    logic       queuePop;

    byteQueue #(
        .Depth (QueueDepth)
    ) queue (
        .clk    (clk),
        .rstN   (rstN),
        .wrEn   (byteValid),
        .wrData (byteData),
        .rdEn   (queuePop),
        .rdData (queueData),
        .full   (byteFull),
        .empty  (queueEmpty)
    );

    instrAssembler assembler (
        .clk         (clk),
        .rstN        (rstN),
        .queueData   (queueData),
        .queueEmpty  (queueEmpty),
        .queuePop    (queuePop),
        .insnValid   (insnValid),
        .insnGroup   (insnGroup),
        .insnOpcode  (insnOpcode),
        .insnOpLen   (insnOpLen),
        .insnOperand (insnOperand)
    );

    // Producer must honor back-pressure
    assert property (@(posedge clk) disable iff (!rstN)
        byteValid |-> !byteFull)
        else $error("Byte written while queue full");

endmodule

/* rtl/z80FrontPkg.sv */
package z80FrontPkg;

    // ****************************************
    // Assembler sequencing
    // ****************************************
    typedef enum logic [1:0] {
        Opcode1  = 2'd0,  // Waiting for first opcode byte
        Opcode2  = 2'd1,  // Prefix seen
        Operands = 2'd2
    } asmState_t;

    // Fetch byte queue
    localparam int defaultQueueDepth = 8;

endpackage

/* rtl/z80IsaPkg.sv */
package z80IsaPkg;

    // ****************************************
    // Instruction groups
    // ****************************************
    typedef enum logic [7:0] {
        NeedMoreBytes = 8'h00,  // Opcode not complete yet
        IllegalInstr  = 8'h01,
        LdDdImmed     = 8'h02,
        LdBcdeA       = 8'h03,
        LdABcde       = 8'h04,
        LdRegImmed    = 8'h05,
        LdExtaddrHl   = 8'h06,
        LdHlImmed     = 8'h07,
        LdRegReg      = 8'h08,
        LdExtaddrA    = 8'h09,
        LdAExtaddr    = 8'h0a,
        LdHlReg       = 8'h0b,
        LdDdExtaddr   = 8'h0c,
        LdExtaddrDd   = 8'h0d,
        LdRegIxiy     = 8'h0e,
        LdIxiyReg     = 8'h0f,
        LdIxiyImmed   = 8'h10,
        LdExtaddrIxiy = 8'h11,
        LdIA          = 8'h12,
        LdAI          = 8'h13
    } insnGroup_t;

    // Opcode prefixes
    localparam logic [7:0] PrefixCb = 8'hcb;
    localparam logic [7:0] PrefixDd = 8'hdd;
    localparam logic [7:0] PrefixEd = 8'hed;
    localparam logic [7:0] PrefixFd = 8'hfd;

    // Operand bytes that follow the opcode
    function automatic logic [1:0] operandCount(input insnGroup_t group);
        case (group)
            LdDdImmed, LdExtaddrHl, LdExtaddrA, LdAExtaddr,
            LdDdExtaddr, LdExtaddrDd, LdExtaddrIxiy:
                operandCount = 2'd2;  // Little-endian word
            LdIxiyImmed:
                operandCount = 2'd2;  // Displacement, then immediate
            LdRegImmed, LdHlImmed:
                operandCount = 2'd1;
            LdRegIxiy, LdIxiyReg:
                operandCount = 2'd1;  // Displacement only
            default:
                operandCount = 2'd0;
        endcase
    endfunction

endpackage

/* run.sh */
#!/bin/sh
# Build the front-end testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f files.f --top-module tbZ80Front; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/VtbZ80Front)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

/* tests/clockGen.sv */
`timescale 1ns/1ps

module clockGen #(
    parameter int Period      = 8,
    parameter int ResetCycles = 8
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

    // Reset held low for the first cycles
    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

/* tests/tbZ80Front.sv */
`timescale 1ns/1ps

module tbZ80Front;

    localparam int WaitLimit = 2000;  // Cycles per wait loop

    typedef struct packed {
        z80IsaPkg::insnGroup_t group;
        logic [15:0]           opcode;
        logic [1:0]            opLen;
        logic [15:0]           operand;
    } insnRec_t;

    logic                  clk;
    logic                  rstN;
    logic                  byteValid;
    logic [7:0]            byteData;
    logic                  byteFull;
    logic                  insnValid;
    z80IsaPkg::insnGroup_t insnGroup;
    logic [15:0]           insnOpcode;
    logic [1:0]            insnOpLen;
    logic [15:0]           insnOperand;

    logic [7:0] stream[$];
    insnRec_t   expQ[$];
    insnRec_t   obsQ[$];
    int         obsEdge[$];
    int         edgeCount = 0;
    int         firstWriteEdge = 0;
    int         seed = 32'hc0179619;
    int         mismatchErrors = 0;
    int         timeoutErrors = 0;

    clockGen #(.Period(8), .ResetCycles(8)) clocks (.clk(clk), .rstN(rstN));

    z80Front dut (
        .clk         (clk),
        .rstN        (rstN),
        .byteValid   (byteValid),
        .byteData    (byteData),
        .byteFull    (byteFull),
        .insnValid   (insnValid),
        .insnGroup   (insnGroup),
        .insnOpcode  (insnOpcode),
        .insnOpLen   (insnOpLen),
        .insnOperand (insnOperand)
    );

    always @(posedge clk) edgeCount <= edgeCount + 1;

    // Output monitor sampling between edges
    always @(negedge clk) begin
        if (rstN && insnValid) begin
            obsQ.push_back({insnGroup, insnOpcode, insnOpLen, insnOperand});
            obsEdge.push_back(edgeCount + 1);  // Edge that samples the pulse
        end
    end

    // ****************************************
    // Reference decode rules
    // ****************************************
    function automatic bit isPrefix(input logic [7:0] b);
        return b == z80IsaPkg::PrefixCb || b == z80IsaPkg::PrefixDd ||
               b == z80IsaPkg::PrefixEd || b == z80IsaPkg::PrefixFd;
    endfunction

    function automatic z80IsaPkg::insnGroup_t groupOfByte(input logic [7:0] b);
        if ((b & 8'hcf) == 8'h01) return z80IsaPkg::LdDdImmed;   // 01 11 21 31
        if (b == 8'h02 || b == 8'h12) return z80IsaPkg::LdBcdeA;
        if (b == 8'h0a || b == 8'h1a) return z80IsaPkg::LdABcde;
        if (b == 8'h36) return z80IsaPkg::LdHlImmed;
        if ((b & 8'hc7) == 8'h06) return z80IsaPkg::LdRegImmed;
        if (b == 8'h22) return z80IsaPkg::LdExtaddrHl;
        if (b == 8'h32) return z80IsaPkg::LdExtaddrA;
        if (b == 8'h3a) return z80IsaPkg::LdAExtaddr;
        // LD r,r' block without (HL) sources
        if (b[7:6] == 2'b01 && b[2:0] != 3'd6) begin
            if (b[5:3] == 3'd6) return z80IsaPkg::LdHlReg;
            return z80IsaPkg::LdRegReg;
        end
        return z80IsaPkg::IllegalInstr;
    endfunction

    function automatic z80IsaPkg::insnGroup_t groupOfPair(input logic [7:0] p,
                                                         input logic [7:0] b);
        if (p == z80IsaPkg::PrefixEd) begin
            if ((b & 8'hcf) == 8'h4b) return z80IsaPkg::LdDdExtaddr;
            if ((b & 8'hcf) == 8'h43) return z80IsaPkg::LdExtaddrDd;
            if (b == 8'h47) return z80IsaPkg::LdIA;
            if (b == 8'h57) return z80IsaPkg::LdAI;
        end else if (p == z80IsaPkg::PrefixDd || p == z80IsaPkg::PrefixFd) begin
            if (b == 8'h36) return z80IsaPkg::LdIxiyImmed;
            if (b == 8'h22) return z80IsaPkg::LdExtaddrIxiy;
            if (b == 8'h76) return z80IsaPkg::IllegalInstr;
            if ((b & 8'hc7) == 8'h46) return z80IsaPkg::LdRegIxiy;
            if ((b & 8'hf8) == 8'h70) return z80IsaPkg::LdIxiyReg;
        end
        return z80IsaPkg::IllegalInstr;
    endfunction

    function automatic int operandBytes(input z80IsaPkg::insnGroup_t g);
        case (g)
            z80IsaPkg::LdDdImmed, z80IsaPkg::LdExtaddrHl, z80IsaPkg::LdExtaddrA,
            z80IsaPkg::LdAExtaddr, z80IsaPkg::LdDdExtaddr, z80IsaPkg::LdExtaddrDd,
            z80IsaPkg::LdExtaddrIxiy, z80IsaPkg::LdIxiyImmed:
                return 2;
            z80IsaPkg::LdRegImmed, z80IsaPkg::LdHlImmed,
            z80IsaPkg::LdRegIxiy, z80IsaPkg::LdIxiyReg:
                return 1;
            default:
                return 0;
        endcase
    endfunction

    // Walks the byte stream into the expected instruction list
    task automatic buildExpected();
        int       i;
        int       n;
        insnRec_t rec;
        expQ.delete();
        i = 0;
        while (i < stream.size()) begin
            rec = '0;
            if (isPrefix(stream[i])) begin
                rec.opcode = {stream[i+1], stream[i]};
                rec.opLen  = 2'd2;
                rec.group  = groupOfPair(stream[i], stream[i+1]);
                i += 2;
            end else begin
                rec.opcode = {8'h00, stream[i]};
                rec.opLen  = 2'd1;
                rec.group  = groupOfByte(stream[i]);
                i += 1;
            end
            n = operandBytes(rec.group);
            assert (int'(z80IsaPkg::operandCount(rec.group)) == n) else begin
                mismatchErrors++;
                $display("Mismatch at %0t: operand count of group %0h", $time, rec.group);
            end
            if (n > 0) rec.operand[7:0] = stream[i];
            if (n > 1) rec.operand[15:8] = stream[i+1];
            i += n;
            expQ.push_back(rec);
        end
    endtask

    // ****************************************
    // Stimulus and checking
    // ****************************************
    task automatic sendStream(input int gapMask);
        int gap;
        int cycles;
        for (int i = 0; i < stream.size(); i++) begin
            gap = $random(seed) & gapMask;
            repeat (gap) begin
                @(posedge clk);
                byteValid <= 1'b0;
            end
            cycles = 0;
            @(negedge clk);
            while (byteFull && cycles < WaitLimit) begin
                @(negedge clk);
                cycles++;
            end
            if (byteFull) begin
                timeoutErrors++;
                $display("Timeout at %0t: byte queue never left full", $time);
            end
            if (i == 0) firstWriteEdge = edgeCount + 2;  // Sampled one edge after driving
            @(posedge clk);
            byteValid <= 1'b1;
            byteData  <= stream[i];
        end
        @(posedge clk);
        byteValid <= 1'b0;
    endtask

    task automatic waitForInsns(input int n);
        int cycles;
        cycles = 0;
        while (obsQ.size() < n && cycles < WaitLimit) begin
            @(posedge clk);
            cycles++;
        end
        if (obsQ.size() < n) begin
            timeoutErrors++;
            $display("Timeout at %0t: only %0d of %0d expected instructions arrived",
                     $time, obsQ.size(), n);
        end
        repeat (4) @(posedge clk);  // Room for any extra pulse
    endtask

    task automatic runCase(input string name, input int gapMask);
        obsQ.delete();
        obsEdge.delete();
        buildExpected();
        sendStream(gapMask);
        waitForInsns(expQ.size());
        assert (obsQ.size() == expQ.size()) else begin
            mismatchErrors++;
            $display("Mismatch at %0t: %s gave %0d instructions, expected %0d",
                     $time, name, obsQ.size(), expQ.size());
        end
        for (int i = 0; i < expQ.size() && i < obsQ.size(); i++) begin
            assert (obsQ[i] == expQ[i]) else begin
                mismatchErrors++;
                $display("Mismatch at %0t: %s insn %0d got %0h %h %0d %h expected %0h %h %0d %h",
                         $time, name, i, obsQ[i].group, obsQ[i].opcode, obsQ[i].opLen,
                         obsQ[i].operand, expQ[i].group, expQ[i].opcode, expQ[i].opLen,
                         expQ[i].operand);
            end
        end
    endtask

    task automatic addRandomInsn();
        int         sel;
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] picks[$];
        picks = '{8'h4b, 8'h43, 8'h47, 8'h57, 8'h7e, 8'h70, 8'h36, 8'h22};
        sel = $random(seed) & 7;
        b0  = 8'($random(seed));
        b1  = 8'($random(seed));
        case (sel)
            0: b0 = z80IsaPkg::PrefixEd;
            1: b0 = z80IsaPkg::PrefixDd;
            2: b0 = z80IsaPkg::PrefixFd;
            3: b0 = z80IsaPkg::PrefixCb;
            default: ;
        endcase
        if (($random(seed) & 1) != 0) b1 = picks[$random(seed) & 7];
        stream.push_back(b0);
        if (isPrefix(b0)) begin
            stream.push_back(b1);
            repeat (operandBytes(groupOfPair(b0, b1))) stream.push_back(8'($random(seed)));
        end else begin
            repeat (operandBytes(groupOfByte(b0))) stream.push_back(8'($random(seed)));
        end
    endtask

    // ****************************************
    // Directed tests
    // ****************************************
    task automatic singleByteLoads();
        logic [7:0] singles[$];
        singles = '{8'h78, 8'h0a, 8'h77, 8'h47, 8'h02, 8'h1a, 8'h7f};
        foreach (singles[k]) begin
            stream = '{singles[k]};
            runCase("single byte", 0);
            assert (obsEdge.size() == 1 && obsEdge[0] == firstWriteEdge + 2) else begin
                mismatchErrors++;
                $display("Mismatch at %0t: byte %h did not pulse insnValid 2 cycles after write",
                         $time, singles[k]);
            end
        end
    endtask

    task automatic immediateLoads();
        stream = '{8'h21, 8'h34, 8'h12, 8'h3e, 8'h5a, 8'h36, 8'ha5, 8'h32, 8'h78,
                   8'h56, 8'h3a, 8'hcd, 8'hab, 8'h01, 8'hef, 8'hbe, 8'h06, 8'h99};
        runCase("immediate", 0);
    endtask

    task automatic prefixedLoads();
        stream = '{8'hed, 8'h4b, 8'h11, 8'h22, 8'hed, 8'h47, 8'hed, 8'h57,
                   8'hdd, 8'h7e, 8'h05, 8'hfd, 8'h70, 8'hfe, 8'hdd, 8'h36, 8'h80,
                   8'h99, 8'hfd, 8'h22, 8'h44, 8'h33, 8'hed, 8'h73, 8'h66, 8'h55};
        runCase("prefixed", 0);
    endtask

    task automatic illegalOpcodes();
        stream = '{8'h76, 8'h78, 8'hed, 8'h00, 8'h3e, 8'h11, 8'hcb, 8'h00,
                   8'h0a, 8'hdd, 8'h21, 8'h21, 8'h34, 8'h12, 8'h46, 8'h77};
        runCase("illegal", 0);
    endtask

    task automatic randomGapStream();
        stream.delete();
        repeat (200) addRandomInsn();
        runCase("random gaps", 3);
    endtask

    task automatic fullRateStream();
        stream.delete();
        repeat (80) addRandomInsn();
        runCase("full rate", 0);  // A byte offered every cycle
    endtask

    initial begin
        int cycles;
        byteValid = 1'b0;
        byteData  = 8'h00;
        cycles    = 0;
        while (rstN !== 1'b1 && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (rstN !== 1'b1) begin
            timeoutErrors++;
            $display("Timeout at %0t: reset was never released", $time);
        end
        @(negedge clk);
        assert (!byteFull) else begin
            mismatchErrors++;
            $display("Mismatch at %0t: byteFull high right after reset", $time);
        end
        singleByteLoads();
        immediateLoads();
        prefixedLoads();
        illegalOpcodes();
        randomGapStream();
        fullRateStream();
        $display("Errors: %0d mismatches, %0d timeouts", mismatchErrors, timeoutErrors);
        if (mismatchErrors + timeoutErrors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
